/* run_sim.sh */
#!/bin/sh
# Build the SoC bus testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module soc_tb -f verilog.f -o soc_sim || exit 1

output=$(./obj_dir/soc_sim)
echo "$output"

echo "$output" | grep -qx "RESULT: PASS" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* src/soc_bus.sv */
// System bus router
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_bus (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::bus_req_t manager_req_i,
  output soc_pkg::bus_rsp_t manager_rsp_o,
  output soc_pkg::bus_req_t device_req_o [`SOC_NUM_DEVICES],
  input  soc_pkg::bus_rsp_t device_rsp_i [`SOC_NUM_DEVICES]
);

  import soc_pkg::*;

  // Indexed by device_e: ram, mtimer, gpio
  localparam logic [31:0] DEV_BASE [`SOC_NUM_DEVICES] =
    '{`SOC_RAM_BASE, `SOC_MTIMER_BASE, `SOC_GPIO_BASE};
  localparam logic [31:0] DEV_SIZE [`SOC_NUM_DEVICES] =
    '{32'(`SOC_RAM_SIZE), 32'(`SOC_REGION_SIZE), 32'(`SOC_REGION_SIZE)};

  logic [`SOC_NUM_DEVICES-1:0] hit;
  logic                        any_hit;
  logic                        req_any;
  device_e                     hit_idx;
  device_e                     sel_q;
  logic                        sel_hit_q;
  logic                        unmapped_rd_q;
  logic                        unmapped_wr_q;

  // ----------------------------------------
  // Address decode and request gating
  // ----------------------------------------
  for (genvar d = 0; d < `SOC_NUM_DEVICES; d++) begin : g_dev
    assign hit[d] = (manager_req_i.rw_address - DEV_BASE[d]) < DEV_SIZE[d];

    always_comb begin
      device_req_o[d]               = manager_req_i;
      device_req_o[d].read_request  = manager_req_i.read_request & hit[d];
      device_req_o[d].write_request = manager_req_i.write_request & hit[d];
    end
  end

  assign any_hit = |hit;
  assign req_any = manager_req_i.read_request | manager_req_i.write_request;

  always_comb begin
    hit_idx = dev_ram;
    for (int i = 0; i < `SOC_NUM_DEVICES; i++) begin
      if (hit[i]) begin
        hit_idx = device_e'(i);
      end
    end
  end

  // ----------------------------------------
  // Response select and unmapped reply
  // ----------------------------------------

  // Remember the target so the response stays routed after the request drops
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sel_q         <= dev_ram;
      sel_hit_q     <= 1'b0;
      unmapped_rd_q <= 1'b0;
      unmapped_wr_q <= 1'b0;
    end else begin
      if (req_any) begin
        sel_q     <= hit_idx;
        sel_hit_q <= any_hit;
      end
      unmapped_rd_q <= manager_req_i.read_request & ~any_hit &
                       ~(unmapped_rd_q | unmapped_wr_q);
      unmapped_wr_q <= manager_req_i.write_request & ~any_hit &
                       ~(unmapped_rd_q | unmapped_wr_q);
    end
  end

  always_comb begin
    if (sel_hit_q) begin
      manager_rsp_o = device_rsp_i[sel_q];
    end else begin
      manager_rsp_o.read_data      = '0;
      manager_rsp_o.read_response  = unmapped_rd_q;
      manager_rsp_o.write_response = unmapped_wr_q;
    end
  end

  // Regions never overlap
  a_onehot_sel: assert property (@(posedge clock) disable iff (reset)
    $onehot0(hit));

  a_no_rd_wr: assert property (@(posedge clock) disable iff (reset)
    !(manager_req_i.read_request && manager_req_i.write_request));

  // Pending access keeps its request and address until answered
  a_req_held: assert property (@(posedge clock) disable iff (reset)
    (req_any && !(manager_rsp_o.read_response || manager_rsp_o.write_response)) |=>
      ((manager_rsp_o.read_response || manager_rsp_o.write_response) ||
       (req_any && $stable(manager_req_i.rw_address))));

endmodule

`default_nettype wire

/* src/soc_gpio.sv */
// GPIO block
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_gpio (
  input  logic               clock,
  input  logic               reset,
  input  soc_pkg::bus_req_t  req_i,
  output soc_pkg::bus_rsp_t  rsp_o,
  input  soc_pkg::gpio_vec_t gpio_input_i,
  output soc_pkg::gpio_vec_t gpio_oe_o,
  output soc_pkg::gpio_vec_t gpio_output_o
);

  import soc_pkg::*;

  gpio_vec_t   sync_meta_q;
  gpio_vec_t   sync_in_q;
  gpio_vec_t   oe_q;
  gpio_vec_t   out_q;
  gpio_vec_t   wr_vec;
  logic [31:0] wr_bits;
  logic [31:0] read_word;
  logic [31:0] read_data_q;
  logic        read_response_q;
  logic        write_response_q;
  logic        busy;
  logic        do_write;
  logic [4:0]  offset;

  assign busy     = read_response_q | write_response_q;
  assign do_write = req_i.write_request & ~busy;
  assign offset   = req_i.rw_address[4:0];
  // Only strobed bytes carry data
  assign wr_bits  = merge_strobe('0, req_i.write_data, req_i.write_strobe);
  assign wr_vec   = wr_bits[`SOC_GPIO_WIDTH-1:0];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sync_meta_q      <= '0;
      sync_in_q        <= '0;
      oe_q             <= '0;
      out_q            <= '0;
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      // Two-flop input synchroniser
      sync_meta_q <= gpio_input_i;
      sync_in_q   <= sync_meta_q;
      if (do_write) begin
        case (offset)
          `SOC_GPIO_OE:  oe_q  <= wr_vec;
          `SOC_GPIO_OUT: out_q <= wr_vec;
          `SOC_GPIO_CLR: out_q <= out_q & ~wr_vec;
          `SOC_GPIO_SET: out_q <= out_q | wr_vec;
          default:       out_q <= out_q;
        endcase
      end
      read_response_q  <= req_i.read_request & ~busy;
      write_response_q <= do_write;
    end
  end

  always_comb begin
    case (offset)
      `SOC_GPIO_IN:                              read_word = 32'(sync_in_q);
      `SOC_GPIO_OE:                              read_word = 32'(oe_q);
      `SOC_GPIO_OUT, `SOC_GPIO_CLR, `SOC_GPIO_SET: read_word = 32'(out_q);
      default:                                   read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (req_i.read_request && !busy) begin
      read_data_q <= read_word;
    end
  end

  assign rsp_o = '{read_data: read_data_q, read_response: read_response_q,
                   write_response: write_response_q};
  assign gpio_oe_o     = oe_q;
  assign gpio_output_o = out_q;

endmodule

`default_nettype wire

/* src/soc_mtimer.sv */
// Machine timer
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_mtimer (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              irq_o
);

  import soc_pkg::*;

  logic        enable_q;
  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtime_next;
  logic        irq_q;
  logic [31:0] read_word;
  logic [31:0] read_data_q;
  logic        read_response_q;
  logic        write_response_q;
  logic        busy;
  logic        do_write;
  logic [4:0]  offset;

  assign busy     = read_response_q | write_response_q;
  assign do_write = req_i.write_request & ~busy;
  assign offset   = req_i.rw_address[4:0];

  // ----------------------------------------
  // Counter
  // ----------------------------------------

  // Bus writes override the increment
  always_comb begin
    mtime_next = enable_q ? mtime_q + 64'd1 : mtime_q;
    if (do_write && offset == `SOC_MTIMER_LO) begin
      mtime_next[31:0] = merge_strobe(mtime_q[31:0], req_i.write_data, req_i.write_strobe);
    end
    if (do_write && offset == `SOC_MTIMER_HI) begin
      mtime_next[63:32] = merge_strobe(mtime_q[63:32], req_i.write_data, req_i.write_strobe);
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      enable_q   <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
    end else begin
      mtime_q <= mtime_next;
      if (do_write && offset == `SOC_MTIMER_CR && req_i.write_strobe[0]) begin
        enable_q <= req_i.write_data[0];
      end
      if (do_write && offset == `SOC_MTIMECMP_LO) begin
        mtimecmp_q[31:0] <= merge_strobe(mtimecmp_q[31:0], req_i.write_data,
                                         req_i.write_strobe);
      end
      if (do_write && offset == `SOC_MTIMECMP_HI) begin
        mtimecmp_q[63:32] <= merge_strobe(mtimecmp_q[63:32], req_i.write_data,
                                          req_i.write_strobe);
      end
      irq_q <= enable_q & (mtime_q >= mtimecmp_q);
    end
  end

  // ----------------------------------------
  // Register read and response
  // ----------------------------------------
  always_comb begin
    case (offset)
      `SOC_MTIMER_CR:   read_word = {31'b0, enable_q};
      `SOC_MTIMER_LO:   read_word = mtime_q[31:0];
      `SOC_MTIMER_HI:   read_word = mtime_q[63:32];
      `SOC_MTIMECMP_LO: read_word = mtimecmp_q[31:0];
      `SOC_MTIMECMP_HI: read_word = mtimecmp_q[63:32];
      default:          read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (req_i.read_request && !busy) begin
      read_data_q <= read_word;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      read_response_q  <= req_i.read_request & ~busy;
      write_response_q <= do_write;
    end
  end

  assign rsp_o = '{read_data: read_data_q, read_response: read_response_q,
                   write_response: write_response_q};
  assign irq_o = irq_q;

  a_irq_off: assert property (@(posedge clock) disable iff (reset)
    !enable_q |=> !irq_o);

endmodule

`default_nettype wire

/* src/soc_pkg.sv */
// SoC bus types
`default_nettype none

`include "soc_settings.svh"

package soc_pkg;

  // One access from the manager
  typedef struct packed {
    logic [31:0] rw_address;
    logic [31:0] write_data;
    logic [3:0]  write_strobe;
    logic        read_request;
    logic        write_request;
  } bus_req_t;

  // Answer from a device
  typedef struct packed {
    logic [31:0] read_data;
    logic        read_response;
    logic        write_response;
  } bus_rsp_t;

  // Device index, order matches the bus decode tables
  typedef enum logic [1:0] {
    dev_ram,
    dev_mtimer,
    dev_gpio
  } device_e;

  typedef logic [`SOC_GPIO_WIDTH-1:0] gpio_vec_t;

  // Byte lanes of new_word replace those of old_word where strobed
  function automatic logic [31:0] merge_strobe(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strobe);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

endpackage

`default_nettype wire

/* src/soc_ram.sv */
// Byte-strobed RAM
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_ram #(
  parameter int MEMORY_SIZE = `SOC_RAM_SIZE
) (
  input  logic              clock,
  input  logic              reset,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  import soc_pkg::*;

  localparam int WORDS   = MEMORY_SIZE / 4;
  localparam int INDEX_W = $clog2(WORDS);

  logic [31:0]        mem [WORDS];
  logic [INDEX_W-1:0] word_index;
  logic [31:0]        read_data_q;
  logic               read_response_q;
  logic               write_response_q;
  logic               busy;

  assign word_index = req_i.rw_address[INDEX_W+1:2];
  // A response in flight means the current request was already served
  assign busy = read_response_q | write_response_q;

  // Word storage and registered read port
  always_ff @(posedge clock) begin
    if (req_i.write_request && !busy) begin
      mem[word_index] <= merge_strobe(mem[word_index], req_i.write_data,
                                      req_i.write_strobe);
    end
    if (req_i.read_request && !busy) begin
      read_data_q <= mem[word_index];
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      read_response_q  <= req_i.read_request & ~busy;
      write_response_q <= req_i.write_request & ~busy;
    end
  end

  assign rsp_o = '{read_data: read_data_q, read_response: read_response_q,
                   write_response: write_response_q};

  a_in_range: assert property (@(posedge clock) disable iff (reset)
    (req_i.read_request || req_i.write_request) |->
      ((req_i.rw_address - 32'(`SOC_RAM_BASE)) < 32'(MEMORY_SIZE)));

endmodule

`default_nettype wire

/* src/soc_settings.svh */
// SoC address map settings
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ----------------------------------------
// Base addresses and region sizes
// ----------------------------------------

// RAM size in bytes, must be a power of two
`define SOC_RAM_BASE      32'h0000_0000
`define SOC_RAM_SIZE      8192
`define SOC_MTIMER_BASE   32'h8001_0000
`define SOC_GPIO_BASE     32'h8002_0000
`define SOC_REGION_SIZE   32

// ----------------------------------------
// Register offsets
// ----------------------------------------
`define SOC_MTIMER_CR     5'h00
`define SOC_MTIMER_LO     5'h04
`define SOC_MTIMER_HI     5'h08
`define SOC_MTIMECMP_LO   5'h0C
`define SOC_MTIMECMP_HI   5'h10

`define SOC_GPIO_IN       5'h00
`define SOC_GPIO_OE       5'h04
`define SOC_GPIO_OUT      5'h08
`define SOC_GPIO_CLR      5'h0C
`define SOC_GPIO_SET      5'h10

`define SOC_GPIO_WIDTH    2
`define SOC_NUM_DEVICES   3

`endif

/* src/soc_top.sv */
// SoC bus subsystem top
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_top (
  input  logic               clock,
  input  logic               reset,
  input  soc_pkg::bus_req_t  bus_i,
  output soc_pkg::bus_rsp_t  bus_o,
  input  soc_pkg::gpio_vec_t gpio_input_i,
  output soc_pkg::gpio_vec_t gpio_oe_o,
  output soc_pkg::gpio_vec_t gpio_output_o,
  output logic               irq_timer_o
);

  import soc_pkg::*;

  // Bus to device links
  bus_req_t device_req [`SOC_NUM_DEVICES];
  bus_rsp_t device_rsp [`SOC_NUM_DEVICES];

  soc_bus soc_bus_instance (
    .clock         (clock),
    .reset         (reset),
    .manager_req_i (bus_i),
    .manager_rsp_o (bus_o),
    .device_req_o  (device_req),
    .device_rsp_i  (device_rsp)
  );

  soc_ram #(
    .MEMORY_SIZE (`SOC_RAM_SIZE)
  ) soc_ram_instance (
    .clock (clock),
    .reset (reset),
    .req_i (device_req[dev_ram]),
    .rsp_o (device_rsp[dev_ram])
  );

  soc_mtimer soc_mtimer_instance (
    .clock (clock),
    .reset (reset),
    .req_i (device_req[dev_mtimer]),
    .rsp_o (device_rsp[dev_mtimer]),
    .irq_o (irq_timer_o)
  );

  soc_gpio soc_gpio_instance (
    .clock         (clock),
    .reset         (reset),
    .req_i         (device_req[dev_gpio]),
    .rsp_o         (device_rsp[dev_gpio]),
    .gpio_input_i  (gpio_input_i),
    .gpio_oe_o     (gpio_oe_o),
    .gpio_output_o (gpio_output_o)
  );

endmodule

`default_nettype wire

/* test/soc_tb.sv */
// SoC bus subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_tb;

  import soc_pkg::*;

  // About 900 accesses at 2 to 3 cycles plus timer waits, with margin
  localparam int CYCLE_LIMIT    = 6000;
  localparam int RAM_WORDS_USED = 64;
  localparam int RAM_WRITES     = 300;
  localparam int RESPONSE_WAIT  = 8;

  logic      clock;
  logic      reset;
  bus_req_t  bus_req;
  bus_rsp_t  bus_rsp;
  gpio_vec_t gpio_input;
  gpio_vec_t gpio_oe;
  gpio_vec_t gpio_output;
  logic      irq_timer;

  // Reference model state
  logic [31:0] ram_model [RAM_WORDS_USED];
  gpio_vec_t   oe_model;
  gpio_vec_t   out_model;
  logic [63:0] cmp_model;

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  soc_top DUT (
    .clock         (clock),
    .reset         (reset),
    .bus_i         (bus_req),
    .bus_o         (bus_rsp),
    .gpio_input_i  (gpio_input),
    .gpio_oe_o     (gpio_oe),
    .gpio_output_o (gpio_output),
    .irq_timer_o   (irq_timer)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Check and model helpers
  // ----------------------------------------
  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: expected 0x%h, actual 0x%h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] byte_mask(input logic [3:0] strobe);
    return {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
  endfunction

  function automatic logic is_mapped(input logic [31:0] address);
    return ((address - `SOC_RAM_BASE) < `SOC_RAM_SIZE) ||
           ((address - `SOC_MTIMER_BASE) < `SOC_REGION_SIZE) ||
           ((address - `SOC_GPIO_BASE) < `SOC_REGION_SIZE);
  endfunction

  // ----------------------------------------
  // Bus driver
  // ----------------------------------------
  task automatic run_access(input logic [31:0] address, input logic [31:0] data,
                            input logic [3:0] strobe, input logic write,
                            output logic [31:0] read_data);
    int   waited;
    logic seen;
    @(negedge clock);
    bus_req.rw_address    = address;
    bus_req.write_data    = data;
    bus_req.write_strobe  = strobe;
    bus_req.read_request  = !write;
    bus_req.write_request = write;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < RESPONSE_WAIT) begin
      @(negedge clock);
      waited++;
      seen = write ? bus_rsp.write_response : bus_rsp.read_response;
    end
    read_data             = bus_rsp.read_data;
    bus_req.read_request  = 1'b0;
    bus_req.write_request = 1'b0;
    if (!seen) begin
      error_count++;
      $display("No response from the bus for the access at address 0x%h", address);
    end else begin
      check("response latency", 32'd1, 32'(waited));
    end
  endtask

  task automatic bus_write(input logic [31:0] address, input logic [31:0] data,
                           input logic [3:0] strobe);
    logic [31:0] unused_data;
    run_access(address, data, strobe, 1'b1, unused_data);
  endtask

  task automatic bus_read(input logic [31:0] address, output logic [31:0] data);
    run_access(address, 32'h0, 4'h0, 1'b0, data);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] prev;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] masked;
    logic [31:0] edges [3];
    logic [3:0]  strobe;
    gpio_vec_t   wr;
    logic        reached;
    int          idx;
    int          writes_done;
    int          waited;

    void'($urandom(65));
    reset      = 1'b1;
    bus_req    = '0;
    gpio_input = '0;
    oe_model   = '0;
    out_model  = '0;
    cmp_model  = '1;
    repeat (4) @(negedge clock);
    reset = 1'b0;

    // Reset state
    check("bus_o.read_response", 32'h0, 32'(bus_rsp.read_response));
    check("bus_o.write_response", 32'h0, 32'(bus_rsp.write_response));
    check("gpio_oe_o", 32'h0, 32'(gpio_oe));
    check("gpio_output_o", 32'h0, 32'(gpio_output));
    check("irq_timer_o", 32'h0, 32'(irq_timer));
    bus_read(`SOC_MTIMER_BASE + 32'(`SOC_MTIMER_CR), rd);
    check("mtimer control", 32'h0, rd);
    bus_read(`SOC_MTIMER_BASE + 32'(`SOC_MTIMER_LO), rd);
    check("mtime low", 32'h0, rd);
    bus_read(`SOC_MTIMER_BASE + 32'(`SOC_MTIMER_HI), rd);
    check("mtime high", 32'h0, rd);

    // RAM fill, then random strobed writes mixed with reads
    for (idx = 0; idx < RAM_WORDS_USED; idx++) begin
      addr = `SOC_RAM_BASE + 32'(idx * 4);
      data = (addr * 32'h9E37_79B9) ^ 32'hA5C3_0F1E;
      bus_write(addr, data, 4'hF);
      ram_model[idx] = data;
    end
    writes_done = 0;
    while (writes_done < RAM_WRITES) begin
      idx  = int'($urandom_range(RAM_WORDS_USED - 1));
      addr = `SOC_RAM_BASE + 32'(idx * 4);
      if ($urandom_range(2) != 0) begin
        data   = $urandom;
        strobe = 4'($urandom);
        bus_write(addr, data, strobe);
        ram_model[idx] = (ram_model[idx] & ~byte_mask(strobe)) | (data & byte_mask(strobe));
        writes_done++;
      end else begin
        bus_read(addr, rd);
        check("ram read_data", ram_model[idx], rd);
      end
    end

    // GPIO outputs through OE, OUT, SET and CLR
    for (idx = 0; idx < 40; idx++) begin
      data   = $urandom;
      strobe = 4'($urandom);
      masked = data & byte_mask(strobe);
      wr     = masked[`SOC_GPIO_WIDTH-1:0];
      case ($urandom_range(3))
        0: begin
          addr     = `SOC_GPIO_BASE + 32'(`SOC_GPIO_OE);
          oe_model = wr;
        end
        1: begin
          addr      = `SOC_GPIO_BASE + 32'(`SOC_GPIO_OUT);
          out_model = wr;
        end
        2: begin
          addr      = `SOC_GPIO_BASE + 32'(`SOC_GPIO_SET);
          out_model = out_model | wr;
        end
        default: begin
          addr      = `SOC_GPIO_BASE + 32'(`SOC_GPIO_CLR);
          out_model = out_model & ~wr;
        end
      endcase
      bus_write(addr, data, strobe);
      check("gpio_oe_o", 32'(oe_model), 32'(gpio_oe));
      check("gpio_output_o", 32'(out_model), 32'(gpio_output));
      bus_read(`SOC_GPIO_BASE + 32'(`SOC_GPIO_OE), rd);
      check("gpio OE readback", 32'(oe_model), rd);
      bus_read(`SOC_GPIO_BASE + 32'(`SOC_GPIO_OUT), rd);
      check("gpio OUT readback", 32'(out_model), rd);
    end

    // GPIO input through the synchroniser
    for (idx = 0; idx < 8; idx++) begin
      @(negedge clock);
      data       = $urandom;
      gpio_input = data[`SOC_GPIO_WIDTH-1:0];
      repeat (3) @(negedge clock);
      bus_read(`SOC_GPIO_BASE + 32'(`SOC_GPIO_IN), rd);
      check("gpio IN readback", 32'(gpio_input), rd);
    end

    // Timer held while disabled, then counting up to the compare value
    bus_read(`SOC_MTIMER_BASE + 32'(`SOC_MTIMER_LO), prev);
    bus_read(`SOC_MTIMER_BASE + 32'(`SOC_MTIMER_LO), rd);
    check("mtime while disabled", prev, rd);
    data      = prev + 32'($urandom_range(100, 20));
    cmp_model = {32'h0, data};
    bus_write(`SOC_MTIMER_BASE + 32'(`SOC_MTIMECMP_LO), cmp_model[31:0], 4'hF);
    bus_write(`SOC_MTIMER_BASE + 32'(`SOC_MTIMECMP_HI), cmp_model[63:32], 4'hF);
    bus_write(`SOC_MTIMER_BASE + 32'(`SOC_MTIMER_CR), 32'h1, 4'hF);
    reached = 1'b0;
    waited  = 0;
    while (!reached && waited < 200) begin
      bus_read(`SOC_MTIMER_BASE + 32'(`SOC_MTIMER_LO), rd);
      if (rd < prev) begin
        error_count++;
        $display("mtime went backwards from 0x%h to 0x%h", prev, rd);
      end
      if (rd < cmp_model[31:0] - 32'd2) begin
        check("irq_timer_o before compare", 32'h0, 32'(irq_timer));
      end
      reached = (rd >= cmp_model[31:0]);
      prev    = rd;
      waited++;
    end
    if (!reached) begin
      error_count++;
      $display("mtime never reached the compare value 0x%h", cmp_model[31:0]);
    end
    waited = 0;
    while (!irq_timer && waited < 3) begin
      @(negedge clock);
      waited++;
    end
    check("irq_timer_o at compare", 32'h1, 32'(irq_timer));
    bus_write(`SOC_MTIMER_BASE + 32'(`SOC_MTIMER_CR), 32'h0, 4'hF);
    @(negedge clock);
    check("irq_timer_o after disable", 32'h0, 32'(irq_timer));

    // Unmapped addresses, random and just past each region
    edges[0] = `SOC_RAM_BASE + `SOC_RAM_SIZE;
    edges[1] = `SOC_MTIMER_BASE + `SOC_REGION_SIZE;
    edges[2] = `SOC_GPIO_BASE + `SOC_REGION_SIZE;
    for (idx = 0; idx < 24; idx++) begin
      if (idx % 2 == 1) begin
        addr = edges[idx % 3];
      end else begin
        do begin
          addr = $urandom & 32'hFFFF_FFFC;
        end while (is_mapped(addr));
      end
      if ((idx / 2) % 2 == 0) begin
        bus_read(addr, rd);
        check("unmapped read_data", 32'h0, rd);
      end else begin
        bus_write(addr, $urandom, 4'hF);
      end
    end
    for (idx = 0; idx < RAM_WORDS_USED; idx++) begin
      bus_read(`SOC_RAM_BASE + 32'(idx * 4), rd);
      check("ram after unmapped", ram_model[idx], rd);
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/soc_pkg.sv
src/soc_bus.sv
src/soc_ram.sv
src/soc_mtimer.sv
src/soc_gpio.sv
src/soc_top.sv
test/soc_tb.sv
